// File: hw/npc_pkg.sv
`default_nettype none

package npc_pkg;

	// compare ops return 0 or 1 in bit 0
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [2:0] {
		LOAD_NONE,
		LOAD_LW,
		LOAD_LH,
		LOAD_LHU,
		LOAD_LB,
		LOAD_LBU
	} load_e;

	typedef enum logic [1:0] {
		STORE_NONE,
		STORE_SW,
		STORE_SH,
		STORE_SB
	} store_e;

	typedef enum logic [1:0] {
		JUMP_NONE,
		JUMP_JAL,
		JUMP_JALR
	} jump_e;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS,
		CSR_ECALL
	} csr_op_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;
	localparam logic [31:0] ECALL_CAUSE = 32'd11;

	// one decoded instruction from decode
	typedef struct packed {
		logic [31:0] src1;
		logic [31:0] src2;
		logic [4:0]  rd;
		alu_op_e     alu_op;
		load_e       load;
		store_e      store;
		logic [31:0] store_data;
		jump_e       jump;
		logic        is_branch;
		logic [31:0] branch_target;
		logic        reg_wen;
		logic [31:0] pc;
		logic [31:0] inst;
		logic [11:0] csr_idx;
		csr_op_e     csr_op;
		logic [31:0] csr_nextpc;
		logic        csr_nextpc_taken;
	} exu_req_t;

	typedef struct packed {
		logic        wb_en;
		logic [4:0]  wb_addr;
		logic [31:0] wb_data;
		logic        redirect_taken;
		logic [31:0] redirect_pc;
		logic        csr_wen;
		logic [11:0] csr_addr;
		logic [31:0] csr_data;
		logic        csr2_wen;
		logic [11:0] csr2_addr;
		logic [31:0] csr2_data;
		logic        mem_err;
		logic [31:0] pc;
		logic [31:0] inst;
	} commit_t;

	// shared by aw and ar
	typedef struct packed {
		logic [31:0] addr;
	} axi_ax_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axi_w_t;

	typedef struct packed {
		logic [31:0] data;
		axi_resp_e   resp;
	} axi_r_t;

	typedef struct packed {
		axi_resp_e resp;
	} axi_b_t;

endpackage

`default_nettype wire

// File: hw/npc_alu.sv
`timescale 1ns/10ps
`default_nettype none

module npc_alu (
	input  wire npc_pkg::alu_op_e alu_op,
	input  wire logic [31:0]      src1,
	input  wire logic [31:0]      src2,
	output logic [31:0]           result
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	// only the low five bits matter for shifts
	assign shamt = src2[4:0];
	assign lt_s  = $signed(src1) < $signed(src2);
	assign lt_u  = src1 < src2;

	always_comb begin
		case (alu_op)
			npc_pkg::ALU_ADD:
				result = src1 + src2;
			npc_pkg::ALU_SUB:
				result = src1 - src2;
			npc_pkg::ALU_AND:
				result = src1 & src2;
			npc_pkg::ALU_OR:
				result = src1 | src2;
			npc_pkg::ALU_XOR:
				result = src1 ^ src2;
			npc_pkg::ALU_SLL:
				result = src1 << shamt;
			npc_pkg::ALU_SRL:
				result = src1 >> shamt;
			npc_pkg::ALU_SRA:
				result = $unsigned($signed(src1) >>> shamt);
			// set-less-than and branch compares share the flags
			npc_pkg::ALU_SLT,
			npc_pkg::ALU_LT:
				result = {31'b0, lt_s};
			npc_pkg::ALU_SLTU,
			npc_pkg::ALU_LTU:
				result = {31'b0, lt_u};
			npc_pkg::ALU_EQ:
				result = {31'b0, src1 == src2};
			npc_pkg::ALU_NE:
				result = {31'b0, src1 != src2};
			npc_pkg::ALU_GE:
				result = {31'b0, !lt_s};
			npc_pkg::ALU_GEU:
				result = {31'b0, !lt_u};
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/npc_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module npc_lsu (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               start,
	input  wire npc_pkg::load_e     load,
	input  wire npc_pkg::store_e    store,
	input  wire logic [31:0]        addr,
	input  wire logic [31:0]        store_data,
	input  wire logic               retire,
	output logic                    done,
	output logic                    err,
	output logic [31:0]             load_data,
	output npc_pkg::axi_ax_t        aw,
	output logic                    awvalid,
	input  wire logic               awready,
	output npc_pkg::axi_w_t         w,
	output logic                    wvalid,
	input  wire logic               wready,
	input  wire npc_pkg::axi_b_t    b,
	input  wire logic               bvalid,
	output logic                    bready,
	output npc_pkg::axi_ax_t        ar,
	output logic                    arvalid,
	input  wire logic               arready,
	input  wire npc_pkg::axi_r_t    r,
	input  wire logic               rvalid,
	output logic                    rready
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_RESP,
		ST_DONE
	} lsu_state_e;

	lsu_state_e  rd_state;
	lsu_state_e  wr_state;
	logic [31:0] rdata_shifted;
	logic [31:0] rdata_ext;
	logic [31:0] load_data_q;
	logic        err_q;

	// read side uses idle, addr, data and done
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= ST_IDLE;
		end else begin
			case (rd_state)
				ST_IDLE:
					if (start && load != npc_pkg::LOAD_NONE)
						rd_state <= ST_ADDR;
				ST_ADDR:
					if (arready)
						rd_state <= ST_DATA;
				ST_DATA:
					if (rvalid)
						rd_state <= ST_DONE;
				ST_DONE:
					if (retire)
						rd_state <= ST_IDLE;
				default:
					rd_state <= ST_IDLE;
			endcase
		end
	end

	// write side walks aw, w then b
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= ST_IDLE;
		end else begin
			case (wr_state)
				ST_IDLE:
					if (start && store != npc_pkg::STORE_NONE)
						wr_state <= ST_ADDR;
				ST_ADDR:
					if (awready)
						wr_state <= ST_DATA;
				ST_DATA:
					if (wready)
						wr_state <= ST_RESP;
				ST_RESP:
					if (bvalid)
						wr_state <= ST_DONE;
				ST_DONE:
					if (retire)
						wr_state <= ST_IDLE;
				default:
					wr_state <= ST_IDLE;
			endcase
		end
	end

	assign arvalid = rd_state == ST_ADDR;
	assign rready  = rd_state == ST_DATA;
	assign awvalid = wr_state == ST_ADDR;
	assign wvalid  = wr_state == ST_DATA;
	assign bready  = wr_state == ST_RESP;
	assign done    = rd_state == ST_DONE || wr_state == ST_DONE;

	assign ar.addr = addr;
	assign aw.addr = addr;

	// replicate data over lanes, strobe picks the bytes
	always_comb begin
		case (store)
			npc_pkg::STORE_SH: begin
				w.data = {2{store_data[15:0]}};
				w.strb = 4'b0011 << {addr[1], 1'b0};
			end
			npc_pkg::STORE_SB: begin
				w.data = {4{store_data[7:0]}};
				w.strb = 4'b0001 << addr[1:0];
			end
			default: begin
				w.data = store_data;
				w.strb = 4'b1111;
			end
		endcase
	end

	// move the addressed byte or half down to lane 0
	assign rdata_shifted = r.data >> {addr[1:0], 3'b000};

	always_comb begin
		case (load)
			npc_pkg::LOAD_LH:
				rdata_ext = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
			npc_pkg::LOAD_LHU:
				rdata_ext = {16'b0, rdata_shifted[15:0]};
			npc_pkg::LOAD_LB:
				rdata_ext = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
			npc_pkg::LOAD_LBU:
				rdata_ext = {24'b0, rdata_shifted[7:0]};
			default:
				rdata_ext = r.data;
		endcase
	end

	// result held until retire
	always_ff @(posedge clk) begin
		if (rvalid && rready) begin
			load_data_q <= rdata_ext;
			err_q       <= r.resp == npc_pkg::RESP_SLVERR;
		end else if (bvalid && bready) begin
			err_q <= b.resp == npc_pkg::RESP_SLVERR;
		end
	end

	assign load_data = load_data_q;
	assign err       = err_q;

endmodule

`default_nettype wire

// File: hw/npc_dsram.sv
`timescale 1ns/10ps
`default_nettype none

module npc_dsram #(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire npc_pkg::axi_ax_t   aw,
	input  wire logic               awvalid,
	output logic                    awready,
	input  wire npc_pkg::axi_w_t    w,
	input  wire logic               wvalid,
	output logic                    wready,
	output npc_pkg::axi_b_t         b,
	output logic                    bvalid,
	input  wire logic               bready,
	input  wire npc_pkg::axi_ax_t   ar,
	input  wire logic               arvalid,
	output logic                    arready,
	output npc_pkg::axi_r_t         r,
	output logic                    rvalid,
	input  wire logic               rready
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY + 1) : 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_RESP
	} sram_state_e;

	logic [31:0]         mem [MEM_WORDS];
	sram_state_e         state;
	logic [CNT_W-1:0]    cnt;
	logic                is_write;
	logic                aw_held;
	logic                w_held;
	npc_pkg::axi_ax_t    aw_q;
	npc_pkg::axi_w_t     w_q;
	logic [31:0]         rdata_q;
	npc_pkg::axi_resp_e  resp_q;
	logic                ar_fire;
	logic                aw_fire;
	logic                w_fire;
	logic                wr_go;
	npc_pkg::axi_ax_t    wr_addr;
	npc_pkg::axi_w_t     wr_beat;
	logic                rd_ok;
	logic                wr_ok;

	// reads win when no write beat is pending
	assign arready = state == S_IDLE && !aw_held && !w_held;
	assign awready = state == S_IDLE && !aw_held && !arvalid;
	assign wready  = state == S_IDLE && !w_held && !arvalid;

	assign ar_fire = arvalid && arready;
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;

	// last write beat may be aw or w
	assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire) && (aw_fire || w_fire);
	assign wr_addr = aw_fire ? aw : aw_q;
	assign wr_beat = w_fire ? w : w_q;

	assign rd_ok = ar.addr[31:2] < MEM_WORDS;
	assign wr_ok = wr_addr.addr[31:2] < MEM_WORDS;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			aw_held  <= 1'b0;
			w_held   <= 1'b0;
			is_write <= 1'b0;
			cnt      <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (ar_fire || wr_go) begin
						state    <= (MEM_LATENCY == 0) ? S_RESP : S_WAIT;
						cnt      <= CNT_W'(MEM_LATENCY - 1);
						is_write <= wr_go;
						aw_held  <= 1'b0;
						w_held   <= 1'b0;
					end else begin
						aw_held <= aw_held || aw_fire;
						w_held  <= w_held || w_fire;
					end
				end
				S_WAIT: begin
					if (cnt == '0)
						state <= S_RESP;
					else
						cnt <= cnt - 1'b1;
				end
				S_RESP: begin
					if ((rvalid && rready) || (bvalid && bready))
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// beat payloads and response data
	always_ff @(posedge clk) begin
		if (aw_fire)
			aw_q <= aw;
		if (w_fire)
			w_q <= w;
		if (ar_fire) begin
			rdata_q <= rd_ok ? mem[ar.addr[IDX_W+1:2]] : 32'b0;
			resp_q  <= rd_ok ? npc_pkg::RESP_OKAY : npc_pkg::RESP_SLVERR;
		end else if (wr_go) begin
			resp_q <= wr_ok ? npc_pkg::RESP_OKAY : npc_pkg::RESP_SLVERR;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go && wr_ok) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_beat.strb[i])
					mem[wr_addr.addr[IDX_W+1:2]][8*i +: 8] <= wr_beat.data[8*i +: 8];
			end
		end
	end

	assign rvalid = state == S_RESP && !is_write;
	assign bvalid = state == S_RESP && is_write;
	assign r.data = rdata_q;
	assign r.resp = resp_q;
	assign b.resp = resp_q;

endmodule

`default_nettype wire

// File: hw/npc_exu.sv
`timescale 1ns/10ps
`default_nettype none

module npc_exu (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire npc_pkg::exu_req_t  req,
	input  wire logic               req_valid,
	output logic                    req_ready,
	output npc_pkg::commit_t        commit,
	output logic                    commit_valid,
	input  wire logic               commit_ready,
	output npc_pkg::alu_op_e        alu_op,
	output logic [31:0]             src1,
	output logic [31:0]             src2,
	input  wire logic [31:0]        alu_result,
	output logic                    lsu_start,
	output npc_pkg::load_e          lsu_load,
	output npc_pkg::store_e         lsu_store,
	output logic [31:0]             lsu_addr,
	output logic [31:0]             lsu_store_data,
	output logic                    lsu_retire,
	input  wire logic               lsu_done,
	input  wire logic [31:0]        lsu_load_data,
	input  wire logic               lsu_err
);

	npc_pkg::exu_req_t req_q;
	logic              stage_valid;
	logic              is_load;
	logic              is_mem;
	logic              ready_go;
	logic              is_jump;
	logic              branch_taken;

	assign is_load  = req_q.load != npc_pkg::LOAD_NONE;
	assign is_mem   = is_load || req_q.store != npc_pkg::STORE_NONE;
	assign ready_go = !is_mem || lsu_done;

	assign commit_valid = stage_valid && ready_go;
	assign lsu_retire   = commit_valid && commit_ready;
	assign req_ready    = !stage_valid || lsu_retire;

	always_ff @(posedge clk) begin
		if (rst)
			stage_valid <= 1'b0;
		else if (req_ready)
			stage_valid <= req_valid;
	end

	always_ff @(posedge clk) begin
		if (req_ready && req_valid)
			req_q <= req;
	end

	assign alu_op = req_q.alu_op;
	assign src1   = req_q.src1;
	assign src2   = req_q.src2;

	// held steady while the instruction sits in the stage
	assign lsu_start      = stage_valid && is_mem;
	assign lsu_load       = req_q.load;
	assign lsu_store      = req_q.store;
	assign lsu_addr       = alu_result;
	assign lsu_store_data = req_q.store_data;

	assign is_jump      = req_q.jump != npc_pkg::JUMP_NONE;
	assign branch_taken = req_q.is_branch && alu_result[0];

	always_comb begin
		commit.redirect_taken = is_jump || branch_taken || req_q.csr_nextpc_taken;
		if (req_q.jump == npc_pkg::JUMP_JAL)
			commit.redirect_pc = alu_result;
		else if (req_q.jump == npc_pkg::JUMP_JALR)
			commit.redirect_pc = {alu_result[31:1], 1'b0};
		else if (branch_taken)
			commit.redirect_pc = req_q.branch_target;
		else if (req_q.csr_nextpc_taken)
			commit.redirect_pc = req_q.csr_nextpc;
		else
			commit.redirect_pc = 32'b0;

		commit.wb_en   = req_q.reg_wen;
		commit.wb_addr = req_q.rd;
		if (is_jump)
			commit.wb_data = req_q.pc + 32'd4;
		else if (is_load)
			commit.wb_data = lsu_load_data;
		else if (req_q.csr_op == npc_pkg::CSR_RW || req_q.csr_op == npc_pkg::CSR_RS)
			commit.wb_data = req_q.src2;
		else
			commit.wb_data = alu_result;

		// ecall saves pc to mepc, cause goes to mcause
		commit.csr_wen  = req_q.csr_op != npc_pkg::CSR_NONE;
		commit.csr_addr = (req_q.csr_op == npc_pkg::CSR_ECALL) ? npc_pkg::CSR_MEPC
			: req_q.csr_idx;
		case (req_q.csr_op)
			npc_pkg::CSR_RW:
				commit.csr_data = req_q.src1;
			npc_pkg::CSR_RS:
				commit.csr_data = alu_result;
			default:
				commit.csr_data = req_q.pc;
		endcase
		commit.csr2_wen  = req_q.csr_op == npc_pkg::CSR_ECALL;
		commit.csr2_addr = commit.csr2_wen ? npc_pkg::CSR_MCAUSE : 12'b0;
		commit.csr2_data = commit.csr2_wen ? npc_pkg::ECALL_CAUSE : 32'b0;

		commit.mem_err = is_mem && lsu_err;
		commit.pc      = req_q.pc;
		commit.inst    = req_q.inst;
	end

endmodule

`default_nettype wire

// File: hw/npc_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module npc_exec_top #(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire npc_pkg::exu_req_t  req,
	input  wire logic               req_valid,
	output logic                    req_ready,
	output npc_pkg::commit_t        commit,
	output logic                    commit_valid,
	input  wire logic               commit_ready
);

	npc_pkg::alu_op_e alu_op;
	logic [31:0]      src1;
	logic [31:0]      src2;
	logic [31:0]      alu_result;

	logic             lsu_start;
	npc_pkg::load_e   lsu_load;
	npc_pkg::store_e  lsu_store;
	logic [31:0]      lsu_addr;
	logic [31:0]      lsu_store_data;
	logic             lsu_retire;
	logic             lsu_done;
	logic [31:0]      lsu_load_data;
	logic             lsu_err;

	// data memory bus between lsu and sram
	npc_pkg::axi_ax_t aw;
	npc_pkg::axi_w_t  w;
	npc_pkg::axi_b_t  b;
	npc_pkg::axi_ax_t ar;
	npc_pkg::axi_r_t  r;
	logic             awvalid;
	logic             awready;
	logic             wvalid;
	logic             wready;
	logic             bvalid;
	logic             bready;
	logic             arvalid;
	logic             arready;
	logic             rvalid;
	logic             rready;

	npc_exu npc_exu_inst (
		.clk            (clk),
		.rst            (rst),
		.req            (req),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.commit         (commit),
		.commit_valid   (commit_valid),
		.commit_ready   (commit_ready),
		.alu_op         (alu_op),
		.src1           (src1),
		.src2           (src2),
		.alu_result     (alu_result),
		.lsu_start      (lsu_start),
		.lsu_load       (lsu_load),
		.lsu_store      (lsu_store),
		.lsu_addr       (lsu_addr),
		.lsu_store_data (lsu_store_data),
		.lsu_retire     (lsu_retire),
		.lsu_done       (lsu_done),
		.lsu_load_data  (lsu_load_data),
		.lsu_err        (lsu_err)
	);

	npc_alu npc_alu_inst (
		.alu_op (alu_op),
		.src1   (src1),
		.src2   (src2),
		.result (alu_result)
	);

	npc_lsu npc_lsu_inst (
		.clk        (clk),
		.rst        (rst),
		.start      (lsu_start),
		.load       (lsu_load),
		.store      (lsu_store),
		.addr       (lsu_addr),
		.store_data (lsu_store_data),
		.retire     (lsu_retire),
		.done       (lsu_done),
		.err        (lsu_err),
		.load_data  (lsu_load_data),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.b          (b),
		.bvalid     (bvalid),
		.bready     (bready),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready)
	);

	npc_dsram #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) npc_dsram_inst (
		.clk     (clk),
		.rst     (rst),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready)
	);

endmodule

`default_nettype wire

// File: verification/npc_exec_vectors.svh
`ifndef NPC_EXEC_VECTORS_SVH
`define NPC_EXEC_VECTORS_SVH

// one call per instruction, applied in this order
// alu: op, src1, src2, result
// branch: op, src1, src2, target, taken
// jump: kind, src1, src2, target
// store: kind, address, data / load: kind, address
// csr: op, csr index, src1, src2, csr write value, next pc, next pc taken
task automatic build_table();
	alu_vec(npc_pkg::ALU_ADD, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
	alu_vec(npc_pkg::ALU_SUB, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe);
	alu_vec(npc_pkg::ALU_AND, 32'hf0f0_ff00, 32'h0ff0_0ff0, 32'h00f0_0f00);
	alu_vec(npc_pkg::ALU_OR, 32'hf0f0_0000, 32'h0000_0f0f, 32'hf0f0_0f0f);
	alu_vec(npc_pkg::ALU_XOR, 32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f);
	// shift amount 0x23 keeps only 3
	alu_vec(npc_pkg::ALU_SLL, 32'h0000_0001, 32'h0000_0023, 32'h0000_0008);
	alu_vec(npc_pkg::ALU_SRL, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
	alu_vec(npc_pkg::ALU_SRA, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
	alu_vec(npc_pkg::ALU_SLT, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
	alu_vec(npc_pkg::ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);

	branch_vec(npc_pkg::ALU_EQ, 32'h0000_0005, 32'h0000_0005, 32'h0000_1000, 1'b1);
	branch_vec(npc_pkg::ALU_NE, 32'h0000_0005, 32'h0000_0005, 32'h0000_2000, 1'b0);
	branch_vec(npc_pkg::ALU_LT, 32'hffff_fff0, 32'h0000_0002, 32'h0000_3000, 1'b1);
	branch_vec(npc_pkg::ALU_GE, 32'h0000_0002, 32'hffff_fff0, 32'h0000_4000, 1'b1);
	branch_vec(npc_pkg::ALU_LTU, 32'hffff_fff0, 32'h0000_0002, 32'h0000_5000, 1'b0);
	branch_vec(npc_pkg::ALU_GEU, 32'hffff_fff0, 32'h0000_0002, 32'h0000_6000, 1'b1);

	jump_vec(npc_pkg::JUMP_JAL, 32'h0000_0100, 32'h0000_0040, 32'h0000_0140);
	jump_vec(npc_pkg::JUMP_JALR, 32'h0000_0203, 32'h0000_0010, 32'h0000_0212);

	// full words first so every later load sees defined bytes
	store_vec(npc_pkg::STORE_SW, 32'h0000_0000, 32'h0bad_f00d);
	store_vec(npc_pkg::STORE_SW, 32'h0000_0010, 32'h8899_aabb);
	store_vec(npc_pkg::STORE_SW, 32'h0000_0014, 32'h1234_d678);
	store_vec(npc_pkg::STORE_SB, 32'h0000_0011, 32'h0000_00c5);
	store_vec(npc_pkg::STORE_SH, 32'h0000_0016, 32'h0000_f00d);
	load_vec(npc_pkg::LOAD_LW, 32'h0000_0010);
	load_vec(npc_pkg::LOAD_LB, 32'h0000_0011);
	load_vec(npc_pkg::LOAD_LBU, 32'h0000_0013);
	load_vec(npc_pkg::LOAD_LB, 32'h0000_0012);
	load_vec(npc_pkg::LOAD_LH, 32'h0000_0016);
	load_vec(npc_pkg::LOAD_LHU, 32'h0000_0014);
	load_vec(npc_pkg::LOAD_LW, 32'h0000_0014);

	// 0x400 is one word past the end and would alias word 0
	store_vec(npc_pkg::STORE_SW, 32'h0000_0400, 32'hdead_beef);
	load_vec(npc_pkg::LOAD_LW, 32'h0000_0400);
	load_vec(npc_pkg::LOAD_LW, 32'h0000_0000);

	csr_vec(npc_pkg::CSR_RW, 12'h300, 32'h0000_1888, 32'h0000_0003, 32'h0000_1888,
		32'h0, 1'b0);
	csr_vec(npc_pkg::CSR_RS, 12'h305, 32'h0000_0080, 32'h0000_1800, 32'h0000_1880,
		32'h0, 1'b0);
	csr_vec(npc_pkg::CSR_ECALL, 12'h000, 32'h0, 32'h0, 32'h0, 32'h8000_0400, 1'b1);
	// return from trap, only the next pc
	csr_vec(npc_pkg::CSR_NONE, 12'h000, 32'h0, 32'h0, 32'h0, 32'h8000_0044, 1'b1);
endtask

`endif

// File: verification/npc_exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module npc_exec_tb;

	localparam int MEM_WORDS   = 256;
	localparam int MEM_LATENCY = 2;

	logic              clk;
	logic              rst;
	npc_pkg::exu_req_t req;
	logic              req_valid;
	logic              req_ready;
	npc_pkg::commit_t  commit;
	logic              commit_valid;
	logic              commit_ready;

	// one entry per instruction
	npc_pkg::exu_req_t  req_tab[$];
	npc_pkg::commit_t   exp_tab[$];
	npc_pkg::axi_resp_e resp_tab[$];
	string              name_tab[$];

	// reference data memory, word indexed
	logic [31:0]        model_mem [int];
	logic [31:0]        next_pc     = 32'h8000_0000;
	logic               table_built = 1'b0;
	int                 n_recv      = 0;
	int                 n_pass      = 0;
	int                 n_fail      = 0;
	int                 n_extra     = 0;
	int                 n_hold_err  = 0;
	int                 test_errs   = 0;
	npc_pkg::axi_resp_e got_resp;

	// stalled commit from the previous edge
	npc_pkg::commit_t   held_commit;
	logic               held_valid  = 1'b0;

	npc_exec_top #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) npc_exec_top_inst (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.commit       (commit),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready)
	);

	function automatic logic in_range(input logic [31:0] addr);
		return addr[31:2] < MEM_WORDS;
	endfunction

	task automatic start_entry(output npc_pkg::exu_req_t r, output npc_pkg::commit_t c);
		r         = '0;
		r.pc      = next_pc;
		r.inst    = {next_pc[23:0], 8'h13};
		r.rd      = (req_tab.size() % 31) + 1;
		c         = '0;
		c.pc      = r.pc;
		c.inst    = r.inst;
		c.wb_addr = r.rd;
		next_pc   = next_pc + 32'd4;
	endtask

	task automatic push_entry(input string name, input npc_pkg::exu_req_t r,
			input npc_pkg::commit_t c, input npc_pkg::axi_resp_e resp);
		name_tab.push_back(name);
		req_tab.push_back(r);
		exp_tab.push_back(c);
		resp_tab.push_back(resp);
	endtask

	task automatic alu_vec(input npc_pkg::alu_op_e op, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] result);
		npc_pkg::exu_req_t r;
		npc_pkg::commit_t  c;
		start_entry(r, c);
		r.alu_op  = op;
		r.src1    = a;
		r.src2    = b;
		r.reg_wen = 1'b1;
		c.wb_en   = 1'b1;
		c.wb_data = result;
		push_entry("alu", r, c, npc_pkg::RESP_OKAY);
	endtask

	task automatic branch_vec(input npc_pkg::alu_op_e op, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] target, input logic taken);
		npc_pkg::exu_req_t r;
		npc_pkg::commit_t  c;
		start_entry(r, c);
		r.alu_op         = op;
		r.src1           = a;
		r.src2           = b;
		r.is_branch      = 1'b1;
		r.branch_target  = target;
		c.redirect_taken = taken;
		c.redirect_pc    = target;
		push_entry("branch", r, c, npc_pkg::RESP_OKAY);
	endtask

	task automatic jump_vec(input npc_pkg::jump_e kind, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] target);
		npc_pkg::exu_req_t r;
		npc_pkg::commit_t  c;
		start_entry(r, c);
		r.alu_op         = npc_pkg::ALU_ADD;
		r.src1           = a;
		r.src2           = b;
		r.jump           = kind;
		r.reg_wen        = 1'b1;
		c.wb_en          = 1'b1;
		c.wb_data        = r.pc + 32'd4;
		c.redirect_taken = 1'b1;
		c.redirect_pc    = target;
		push_entry("jump", r, c, npc_pkg::RESP_OKAY);
	endtask

	task automatic store_vec(input npc_pkg::store_e kind, input logic [31:0] addr,
			input logic [31:0] data);
		npc_pkg::exu_req_t r;
		npc_pkg::commit_t  c;
		logic [31:0]       word;
		logic [31:0]       lanes;
		logic [3:0]        strb;
		int                idx;
		start_entry(r, c);
		r.alu_op     = npc_pkg::ALU_ADD;
		r.src1       = addr;
		r.store      = kind;
		r.store_data = data;
		idx          = addr[31:2];
		case (kind)
			npc_pkg::STORE_SB: begin
				strb  = 4'b0001 << addr[1:0];
				lanes = {4{data[7:0]}};
			end
			npc_pkg::STORE_SH: begin
				strb  = addr[1] ? 4'b1100 : 4'b0011;
				lanes = {2{data[15:0]}};
			end
			default: begin
				strb  = 4'b1111;
				lanes = data;
			end
		endcase
		if (in_range(addr)) begin
			word = model_mem.exists(idx) ? model_mem[idx] : 32'hxxxx_xxxx;
			for (int i = 0; i < 4; i++) begin
				if (strb[i])
					word[8*i +: 8] = lanes[8*i +: 8];
			end
			model_mem[idx] = word;
			push_entry("store", r, c, npc_pkg::RESP_OKAY);
		end else begin
			push_entry("store out of range", r, c, npc_pkg::RESP_SLVERR);
		end
	endtask

	task automatic load_vec(input npc_pkg::load_e kind, input logic [31:0] addr);
		npc_pkg::exu_req_t r;
		npc_pkg::commit_t  c;
		logic [31:0]       word;
		logic [7:0]        byte_val;
		logic [15:0]       half_val;
		int                idx;
		int                lane;
		start_entry(r, c);
		r.alu_op  = npc_pkg::ALU_ADD;
		r.src1    = addr;
		r.load    = kind;
		r.reg_wen = 1'b1;
		c.wb_en   = 1'b1;
		idx       = addr[31:2];
		lane      = addr[1:0];
		// out of range reads return zero data
		if (!in_range(addr))
			word = 32'h0;
		else
			word = model_mem.exists(idx) ? model_mem[idx] : 32'hxxxx_xxxx;
		byte_val = word[8*lane +: 8];
		half_val = word[16*(lane/2) +: 16];
		case (kind)
			npc_pkg::LOAD_LB:
				c.wb_data = {{24{byte_val[7]}}, byte_val};
			npc_pkg::LOAD_LBU:
				c.wb_data = {24'h0, byte_val};
			npc_pkg::LOAD_LH:
				c.wb_data = {{16{half_val[15]}}, half_val};
			npc_pkg::LOAD_LHU:
				c.wb_data = {16'h0, half_val};
			default:
				c.wb_data = word;
		endcase
		if (in_range(addr))
			push_entry("load", r, c, npc_pkg::RESP_OKAY);
		else
			push_entry("load out of range", r, c, npc_pkg::RESP_SLVERR);
	endtask

	task automatic csr_vec(input npc_pkg::csr_op_e op, input logic [11:0] idx,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] csr_val,
			input logic [31:0] target, input logic taken);
		npc_pkg::exu_req_t r;
		npc_pkg::commit_t  c;
		start_entry(r, c);
		r.alu_op           = npc_pkg::ALU_OR;
		r.src1             = a;
		r.src2             = b;
		r.csr_idx          = idx;
		r.csr_op           = op;
		r.csr_nextpc       = target;
		r.csr_nextpc_taken = taken;
		r.reg_wen          = op == npc_pkg::CSR_RW || op == npc_pkg::CSR_RS;
		// old csr value comes in on src2
		c.wb_en            = r.reg_wen;
		c.wb_data          = b;
		c.redirect_taken   = taken;
		c.redirect_pc      = target;
		if (op == npc_pkg::CSR_ECALL) begin
			c.csr_wen   = 1'b1;
			c.csr_addr  = npc_pkg::CSR_MEPC;
			c.csr_data  = r.pc;
			c.csr2_wen  = 1'b1;
			c.csr2_addr = npc_pkg::CSR_MCAUSE;
			c.csr2_data = npc_pkg::ECALL_CAUSE;
		end else if (op != npc_pkg::CSR_NONE) begin
			c.csr_wen  = 1'b1;
			c.csr_addr = idx;
			c.csr_data = csr_val;
		end
		push_entry("csr", r, c, npc_pkg::RESP_OKAY);
	endtask

	`include "npc_exec_vectors.svh"

	task automatic compare_field(input int idx, input string field,
			input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0d ns: test %0d %s is %h, expected %h",
				$time, idx, field, got, want);
			test_errs++;
		end
	endtask

	// fields behind a low enable are not compared
	task automatic check_commit(input int idx, input npc_pkg::commit_t got,
			input npc_pkg::commit_t want);
		compare_field(idx, "wb_en", got.wb_en, want.wb_en);
		if (want.wb_en) begin
			compare_field(idx, "wb_addr", got.wb_addr, want.wb_addr);
			compare_field(idx, "wb_data", got.wb_data, want.wb_data);
		end
		compare_field(idx, "redirect_taken", got.redirect_taken, want.redirect_taken);
		if (want.redirect_taken)
			compare_field(idx, "redirect_pc", got.redirect_pc, want.redirect_pc);
		compare_field(idx, "csr_wen", got.csr_wen, want.csr_wen);
		if (want.csr_wen) begin
			compare_field(idx, "csr_addr", got.csr_addr, want.csr_addr);
			compare_field(idx, "csr_data", got.csr_data, want.csr_data);
		end
		compare_field(idx, "csr2_wen", got.csr2_wen, want.csr2_wen);
		if (want.csr2_wen) begin
			compare_field(idx, "csr2_addr", got.csr2_addr, want.csr2_addr);
			compare_field(idx, "csr2_data", got.csr2_data, want.csr2_data);
		end
		compare_field(idx, "pc", got.pc, want.pc);
		compare_field(idx, "inst", got.inst, want.inst);
	endtask

	task automatic check_resp(input int idx, input npc_pkg::axi_resp_e got,
			input npc_pkg::axi_resp_e want);
		if (got !== want) begin
			$display("MISMATCH at %0d ns: test %0d memory response is %b, expected %b",
				$time, idx, got, want);
			test_errs++;
		end
	endtask

	task automatic drive_requests();
		int gap;
		foreach (req_tab[i]) begin
			gap = $urandom_range(3, 0);
			repeat (gap) begin
				@(negedge clk);
				req_valid = 1'b0;
			end
			@(negedge clk);
			req       = req_tab[i];
			req_valid = 1'b1;
			@(posedge clk);
			while (!req_ready)
				@(posedge clk);
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	// back-pressure, ready about three cycles in four
	task automatic toggle_commit_ready();
		forever begin
			@(negedge clk);
			commit_ready = $urandom_range(3, 0) != 0;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst && commit_valid && commit_ready) begin
			if (n_recv >= req_tab.size()) begin
				$display("ERROR at %0d ns: commit for pc %h arrived after the last test",
					$time, commit.pc);
				n_extra++;
			end else begin
				test_errs = 0;
				got_resp  = commit.mem_err ? npc_pkg::RESP_SLVERR : npc_pkg::RESP_OKAY;
				check_commit(n_recv, commit, exp_tab[n_recv]);
				check_resp(n_recv, got_resp, resp_tab[n_recv]);
				if (test_errs == 0) begin
					$display("test %0d %s pc %h: pass", n_recv, name_tab[n_recv], commit.pc);
					n_pass++;
				end else begin
					$display("test %0d %s pc %h: FAIL", n_recv, name_tab[n_recv], commit.pc);
					n_fail++;
				end
			end
			n_recv++;
		end
	end

	// a stalled commit keeps valid and payload, and blocks new requests
	always @(posedge clk) begin
		if (!rst && held_valid) begin
			if (!commit_valid) begin
				$display("ERROR at %0d ns: commit for pc %h was dropped before its transfer",
					$time, held_commit.pc);
				n_hold_err++;
			end else if (commit !== held_commit) begin
				$display("MISMATCH at %0d ns: commit for pc %h changed while stalled",
					$time, held_commit.pc);
				n_hold_err++;
			end
		end
		if (!rst && commit_valid && !commit_ready && req_ready !== 1'b0) begin
			$display("MISMATCH at %0d ns: req_ready is %b while the commit is stalled",
				$time, req_ready);
			n_hold_err++;
		end
		held_valid  = !rst && commit_valid && !commit_ready;
		held_commit = commit;
	end

	initial begin : watchdog
		int limit;
		wait (table_built);
		limit = req_tab.size() * (2 * MEM_LATENCY + 40);
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles: only %0d of %0d commits arrived",
			limit, n_recv, req_tab.size());
		$display("Something failed");
		$finish;
	end

	initial begin : main
		void'($urandom(78028));
		rst          = 1'b1;
		req          = '0;
		req_valid    = 1'b0;
		commit_ready = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fork
			drive_requests();
			toggle_commit_ready();
		join_none
		wait (n_recv >= req_tab.size());
		// catch any commit beyond the table
		repeat (10) @(posedge clk);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d extra commits, %0d stall errors",
			req_tab.size(), n_pass, n_fail, n_extra, n_hold_err);
		if (n_fail == 0 && n_extra == 0 && n_hold_err == 0 && n_pass == req_tab.size())
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verification
hw/npc_pkg.sv
hw/npc_alu.sv
hw/npc_lsu.sv
hw/npc_dsram.sv
hw/npc_exu.sv
hw/npc_exec_top.sv
verification/npc_exec_tb.sv

// File: Bender.yml
package:
  name: npc_exec

sources:
  - files:
      - hw/npc_pkg.sv
      - hw/npc_alu.sv
      - hw/npc_lsu.sv
      - hw/npc_dsram.sv
      - hw/npc_exu.sv
      - hw/npc_exec_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/npc_exec_tb.sv
